// File: common/cpu_pkg.sv
// CPU shared definitions
`default_nettype none

package cpu_pkg;

  localparam int XLEN = 32;

  // Supported RV32I major opcodes
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_AND    = 4'd2,
    ALU_OR     = 4'd3,
    ALU_XOR    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_PASS_B = 4'd6
  } alu_op_e;

  // Branch condition codes
  localparam logic [1:0] BR_NONE = 2'd0;
  localparam logic [1:0] BR_EQ   = 2'd1;
  localparam logic [1:0] BR_NE   = 2'd2;
  localparam logic [1:0] BR_LT   = 2'd3;

  // Memory-mapped keypad word
  localparam logic [XLEN-1:0] KEYPAD_ADDR = 32'h0000_0F00;

endpackage

`default_nettype wire

// File: core/control_unit.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module control_unit import cpu_pkg::*; (
  input  opcode_e    opcode_i,
  input  logic [2:0] funct3_i,
  input  logic       bit30_i,
  output alu_op_e    alu_op_o,
  output logic       alu_src_o,
  output logic       mem_rd_o,
  output logic       mem_wr_o,
  output logic       reg_wr_o,
  output logic       mem_to_reg_o,
  output logic       jump_o,
  output logic       auipc_o,
  output logic [1:0] branch_o
);

  alu_op_e arith_op;
  logic    arith_ok;

  // funct3 to ALU op for both register and immediate forms
  always_comb begin
    arith_ok = 1'b1;
    case (funct3_i)
      3'b000:  arith_op = ALU_ADD;
      3'b010:  arith_op = ALU_SLT;
      3'b100:  arith_op = ALU_XOR;
      3'b110:  arith_op = ALU_OR;
      3'b111:  arith_op = ALU_AND;
      default: begin
        arith_op = ALU_ADD;
        arith_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    alu_op_o     = ALU_ADD;
    alu_src_o    = 1'b0;
    mem_rd_o     = 1'b0;
    mem_wr_o     = 1'b0;
    reg_wr_o     = 1'b0;
    mem_to_reg_o = 1'b0;
    jump_o       = 1'b0;
    auipc_o      = 1'b0;
    branch_o     = BR_NONE;
    case (opcode_i)
      OP_LUI: begin
        alu_op_o  = ALU_PASS_B;
        alu_src_o = 1'b1;
        reg_wr_o  = 1'b1;
      end
      OP_AUIPC: begin
        alu_src_o = 1'b1;
        auipc_o   = 1'b1;
        reg_wr_o  = 1'b1;
      end
      OP_IMM: begin
        // bit 30 belongs to the immediate here
        alu_op_o  = arith_op;
        alu_src_o = 1'b1;
        reg_wr_o  = arith_ok;
      end
      OP_REG: begin
        alu_op_o = (funct3_i == 3'b000 && bit30_i) ? ALU_SUB : arith_op;
        reg_wr_o = arith_ok;
      end
      OP_LOAD: begin
        alu_src_o    = 1'b1;
        mem_rd_o     = 1'b1;
        reg_wr_o     = 1'b1;
        mem_to_reg_o = 1'b1;
      end
      OP_STORE: begin
        alu_src_o = 1'b1;
        mem_wr_o  = 1'b1;
      end
      OP_BRANCH: begin
        alu_op_o = ALU_SUB;
        case (funct3_i)
          3'b000:  branch_o = BR_EQ;
          3'b001:  branch_o = BR_NE;
          3'b100:  branch_o = BR_LT;
          default: branch_o = BR_NONE;
        endcase
      end
      OP_JAL: begin
        jump_o   = 1'b1;
        reg_wr_o = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: core/alu.sv
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  output logic [XLEN-1:0] result_o,
  output logic            zero_o,
  output logic            less_o
);

  logic [XLEN-1:0] diff;
  logic            lt;

  assign diff = a_i - b_i;
  assign lt   = $signed(a_i) < $signed(b_i);

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = diff;
      ALU_AND:    result_o = a_i & b_i;
      ALU_OR:     result_o = a_i | b_i;
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt};
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

  // Branch flags do not depend on the selected op
  assign zero_o = (diff == '0);
  assign less_o = lt;

endmodule

`default_nettype wire

// File: core/register_file.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            we_i,
  input  logic [4:0]      rs1_i,
  input  logic [4:0]      rs2_i,
  input  logic [4:0]      rd_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic [XLEN-1:0] rdata1_o,
  output logic [XLEN-1:0] rdata2_o
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 always reads zero
  assign rdata1_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
  assign rdata2_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: core/cpu_core.sv
// Multi-cycle RV32I core
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            ihit_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            dhit_i,
  input  logic [XLEN-1:0] data_rdata_i,
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_adr_o,
  output logic            data_rd_o,
  output logic            data_wr_o,
  output logic [XLEN-1:0] data_adr_o,
  output logic [XLEN-1:0] data_wdata_o
);

  typedef enum logic [1:0] {S_FETCH, S_EXEC, S_MEM, S_WRITEBACK} state_e;

  state_e          state_q;
  logic            pending_q;
  logic [XLEN-1:0] pc_q, ir_q, load_q;
  opcode_e         opcode;
  alu_op_e         alu_op;
  logic            alu_src, mem_rd, mem_wr, reg_wr, mem_to_reg, jump, auipc;
  logic [1:0]      branch;
  logic [XLEN-1:0] imm, rdata1, rdata2, alu_a, alu_b, alu_result;
  logic [XLEN-1:0] pc_plus4, pc_target, wdata;
  logic            zero, less, taken, rf_we;

  assign opcode = opcode_e'(ir_q[6:0]);

  control_unit u_control (
    .opcode_i     (opcode),
    .funct3_i     (ir_q[14:12]),
    .bit30_i      (ir_q[30]),
    .alu_op_o     (alu_op),
    .alu_src_o    (alu_src),
    .mem_rd_o     (mem_rd),
    .mem_wr_o     (mem_wr),
    .reg_wr_o     (reg_wr),
    .mem_to_reg_o (mem_to_reg),
    .jump_o       (jump),
    .auipc_o      (auipc),
    .branch_o     (branch)
  );

  // Immediate by instruction format
  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC: imm = {ir_q[31:12], 12'b0};
      OP_STORE:  imm = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
      OP_BRANCH: imm = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
      OP_JAL:    imm = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};
      default:   imm = {{20{ir_q[31]}}, ir_q[31:20]};
    endcase
  end

  register_file u_regs (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .we_i     (rf_we),
    .rs1_i    (ir_q[19:15]),
    .rs2_i    (ir_q[24:20]),
    .rd_i     (ir_q[11:7]),
    .wdata_i  (wdata),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  assign alu_a = auipc ? pc_q : rdata1;
  assign alu_b = alu_src ? imm : rdata2;

  alu u_alu (
    .alu_op_i (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result),
    .zero_o   (zero),
    .less_o   (less)
  );

  always_comb begin
    case (branch)
      BR_EQ:   taken = zero;
      BR_NE:   taken = !zero;
      BR_LT:   taken = less;
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4  = pc_q + 32'd4;
  assign pc_target = pc_q + imm;
  assign wdata     = jump ? pc_plus4 : (mem_to_reg ? load_q : alu_result);
  assign rf_we     = reg_wr && (state_q == S_WRITEBACK);

  // Request strobes last one cycle, then wait for the hit
  assign instr_req_o  = (state_q == S_FETCH) && !pending_q;
  assign instr_adr_o  = pc_q;
  assign data_rd_o    = (state_q == S_MEM) && !pending_q && mem_rd;
  assign data_wr_o    = (state_q == S_MEM) && !pending_q && mem_wr;
  assign data_adr_o   = alu_result;
  assign data_wdata_o = rdata2;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= S_FETCH;
      pending_q <= 1'b0;
      pc_q      <= RESET_PC;
    end else begin
      case (state_q)
        S_FETCH: begin
          pending_q <= !ihit_i;
          if (ihit_i) state_q <= S_EXEC;
        end
        S_EXEC: state_q <= (mem_rd || mem_wr) ? S_MEM : S_WRITEBACK;
        S_MEM: begin
          pending_q <= !dhit_i;
          if (dhit_i) state_q <= S_WRITEBACK;
        end
        default: begin
          pc_q    <= (jump || taken) ? pc_target : pc_plus4;
          state_q <= S_FETCH;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_FETCH && ihit_i) ir_q <= instr_rdata_i;
    if (state_q == S_MEM && dhit_i) load_q <= data_rdata_i;
  end

endmodule

`default_nettype wire

// File: rtl/request_unit.sv
// Bus request unit
`timescale 1ns/1ps
`default_nettype none

module request_unit import cpu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            instr_req_i,
  input  logic [XLEN-1:0] instr_adr_i,
  input  logic            data_rd_i,
  input  logic            data_wr_i,
  input  logic [XLEN-1:0] data_adr_i,
  input  logic [XLEN-1:0] data_wdata_i,
  input  logic            busy_i,
  input  logic [XLEN-1:0] dat_i,
  input  logic            key_valid_i,
  input  logic [3:0]      key_code_i,
  output logic            ihit_o,
  output logic            dhit_o,
  output logic [XLEN-1:0] instr_rdata_o,
  output logic [XLEN-1:0] data_rdata_o,
  output logic            read_o,
  output logic            write_o,
  output logic [XLEN-1:0] adr_o,
  output logic [XLEN-1:0] dat_o,
  output logic            key_clear_o
);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT_BUSY, S_WAIT_DONE} state_e;

  state_e          state_q;
  logic            is_data_q, is_write_q, key_hit_q;
  logic [XLEN-1:0] adr_q, dat_q;
  logic            key_rd, bus_done;

  // Keypad reads are answered locally
  assign key_rd = data_rd_i && (data_adr_i == KEYPAD_ADDR);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= S_IDLE;
      is_data_q  <= 1'b0;
      is_write_q <= 1'b0;
      key_hit_q  <= 1'b0;
    end else begin
      key_hit_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (key_rd) begin
            key_hit_q <= 1'b1;
          end else if (instr_req_i) begin
            is_data_q  <= 1'b0;
            is_write_q <= 1'b0;
            state_q    <= S_ISSUE;
          end else if (data_rd_i || data_wr_i) begin
            is_data_q  <= 1'b1;
            is_write_q <= data_wr_i;
            state_q    <= S_ISSUE;
          end
        end
        S_ISSUE:     state_q <= S_WAIT_BUSY;
        S_WAIT_BUSY: if (busy_i) state_q <= S_WAIT_DONE;
        default:     if (!busy_i) state_q <= S_IDLE;
      endcase
    end
  end

  // Address and write data held until completion
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE) begin
      adr_q <= instr_req_i ? instr_adr_i : data_adr_i;
      dat_q <= data_wdata_i;
    end
  end

  assign read_o   = (state_q == S_ISSUE) && !is_write_q;
  assign write_o  = (state_q == S_ISSUE) && is_write_q;
  assign adr_o    = adr_q;
  assign dat_o    = dat_q;

  // First cycle with busy low after it was high
  assign bus_done = (state_q == S_WAIT_DONE) && !busy_i;

  assign ihit_o        = bus_done && !is_data_q;
  assign dhit_o        = (bus_done && is_data_q) || key_hit_q;
  assign instr_rdata_o = dat_i;
  assign data_rdata_o  = key_hit_q ? {key_valid_i, {(XLEN-5){1'b0}}, key_code_i} : dat_i;
  assign key_clear_o   = key_hit_q;

endmodule

`default_nettype wire

// File: rtl/keypad_scanner.sv
// 4x4 keypad scanner
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner #(
  parameter int unsigned SCAN_DIV = 16
) (
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic [3:0] rows_i,
  input  logic       key_clear_i,
  output logic [3:0] cols_o,
  output logic       key_valid_o,
  output logic [3:0] key_code_o
);

  localparam int unsigned DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  logic [DIV_W-1:0] div_q;
  logic [1:0]       col_q;
  logic [3:0]       slot_rows_q;
  logic             scan_seen_q, held_q;
  logic             slot_end, any_low;
  logic [3:0]       rows_low;
  logic [1:0]       row_idx;

  assign slot_end = (div_q == DIV_W'(SCAN_DIV - 1));
  assign rows_low = slot_rows_q | ~rows_i;
  assign any_low  = |rows_low;
  assign cols_o   = ~(4'b0001 << col_q);

  // Lowest row wins
  always_comb begin
    row_idx = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (rows_low[i]) row_idx = 2'(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_q       <= '0;
      col_q       <= 2'd0;
      slot_rows_q <= 4'b0;
      scan_seen_q <= 1'b0;
      held_q      <= 1'b0;
      key_valid_o <= 1'b0;
      key_code_o  <= 4'd0;
    end else begin
      if (key_clear_i) key_valid_o <= 1'b0;
      if (slot_end) begin
        div_q       <= '0;
        col_q       <= col_q + 2'd1;
        slot_rows_q <= 4'b0;
        if (any_low && !held_q) begin
          key_valid_o <= 1'b1;
          key_code_o  <= {col_q, row_idx};
          held_q      <= 1'b1;
        end
        // Release after a full scan with no row low
        if (col_q == 2'd3) begin
          scan_seen_q <= 1'b0;
          if (!scan_seen_q && !any_low) held_q <= 1'b0;
        end else begin
          scan_seen_q <= scan_seen_q | any_low;
        end
      end else begin
        div_q       <= div_q + 1'b1;
        slot_rows_q <= rows_low;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
// CPU subsystem top
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0,
  parameter int unsigned     SCAN_DIV = 16
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            busy_i,
  input  logic [XLEN-1:0] dat_i,
  input  logic [3:0]      rows_i,
  output logic            read_o,
  output logic            write_o,
  output logic [XLEN-1:0] adr_o,
  output logic [XLEN-1:0] dat_o,
  output logic [3:0]      cols_o
);

  logic            instr_req, ihit, data_rd, data_wr, dhit;
  logic [XLEN-1:0] instr_adr, instr_rdata, data_adr, data_wdata, data_rdata;
  logic            key_valid, key_clear;
  logic [3:0]      key_code;

  cpu_core #(.RESET_PC(RESET_PC)) u_core (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .ihit_i        (ihit),
    .instr_rdata_i (instr_rdata),
    .dhit_i        (dhit),
    .data_rdata_i  (data_rdata),
    .instr_req_o   (instr_req),
    .instr_adr_o   (instr_adr),
    .data_rd_o     (data_rd),
    .data_wr_o     (data_wr),
    .data_adr_o    (data_adr),
    .data_wdata_o  (data_wdata)
  );

  request_unit u_req (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_req_i   (instr_req),
    .instr_adr_i   (instr_adr),
    .data_rd_i     (data_rd),
    .data_wr_i     (data_wr),
    .data_adr_i    (data_adr),
    .data_wdata_i  (data_wdata),
    .busy_i        (busy_i),
    .dat_i         (dat_i),
    .key_valid_i   (key_valid),
    .key_code_i    (key_code),
    .ihit_o        (ihit),
    .dhit_o        (dhit),
    .instr_rdata_o (instr_rdata),
    .data_rdata_o  (data_rdata),
    .read_o        (read_o),
    .write_o       (write_o),
    .adr_o         (adr_o),
    .dat_o         (dat_o),
    .key_clear_o   (key_clear)
  );

  keypad_scanner #(.SCAN_DIV(SCAN_DIV)) u_keypad (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .rows_i      (rows_i),
    .key_clear_i (key_clear),
    .cols_o      (cols_o),
    .key_valid_o (key_valid),
    .key_code_o  (key_code)
  );

endmodule

`default_nettype wire

// File: sim/bus_mem_model.sv
// Bus memory model
`timescale 1ns/1ps
`default_nettype none

module bus_mem_model #(
  parameter int WORDS = 1024
) (
  input  wire logic        clk,
  input  wire logic        rst_n_i,
  input  wire logic        read_i,
  input  wire logic        write_i,
  input  wire logic [31:0] adr_i,
  input  wire logic [31:0] dat_i,
  input  wire logic [2:0]  extra_i,
  output logic             busy_o,
  output logic [31:0]      dat_o
);

  localparam int AW = $clog2(WORDS);

  logic [31:0] mem [WORDS];
  // One store log entry per write
  logic [31:0] log_adr [64];
  logic [31:0] log_dat [64];
  int          log_cnt;
  int          cnt;
  logic [31:0] adr_q;
  logic        wr_q;

  initial begin
    busy_o  = 1'b0;
    dat_o   = '0;
    log_cnt = 0;
    cnt     = 0;
    adr_q   = '0;
    wr_q    = 1'b0;
  end

  // Strobes are sampled mid-cycle, busy and read data change on the falling edge
  always @(negedge clk) begin
    if (!rst_n_i) begin
      busy_o  = 1'b0;
      cnt     = 0;
      log_cnt = 0;
    end else if (busy_o) begin
      if (cnt == 0) begin
        busy_o = 1'b0;
        if (!wr_q) dat_o = mem[adr_q[AW+1:2]];
      end else begin
        cnt = cnt - 1;
      end
    end else if (read_i || write_i) begin
      // Busy must still be high when the request unit looks for it
      busy_o = 1'b1;
      cnt    = extra_i + 1;
      adr_q  = adr_i;
      wr_q   = write_i;
      if (write_i) begin
        mem[adr_i[AW+1:2]] = dat_i;
        log_adr[log_cnt]   = adr_i;
        log_dat[log_cnt]   = dat_i;
        log_cnt            = log_cnt + 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_cpu_top.sv
// CPU subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

  localparam logic [31:0] RESET_PC  = 32'h40;
  localparam int          MEM_WORDS = 1024;
  localparam logic [31:0] DONE_ADR  = 32'h3FC;
  // Summed instruction counts at twelve cycles each plus a margin
  localparam int          INSTR_TOTAL = 180;
  localparam int          MAX_CYCLES  = INSTR_TOTAL * 12 + 3000;

  logic        clk, rst_n, busy, rand_busy;
  logic [31:0] dat_in, adr, dat_out, lfsr;
  logic [3:0]  rows, cols;
  logic        rd, wr, key_down;
  logic [2:0]  busy_extra;
  int          errors, checks, cycles, prog_idx, exp_cnt;
  logic [31:0] exp_adr [32];
  logic [31:0] exp_dat [32];

  cpu_top #(.RESET_PC(RESET_PC), .SCAN_DIV(4)) UUT (
    .clk     (clk),
    .rst_n_i (rst_n),
    .busy_i  (busy),
    .dat_i   (dat_in),
    .rows_i  (rows),
    .read_o  (rd),
    .write_o (wr),
    .adr_o   (adr),
    .dat_o   (dat_out),
    .cols_o  (cols)
  );

  bus_mem_model #(.WORDS(MEM_WORDS)) mem_model (
    .clk     (clk),
    .rst_n_i (rst_n),
    .read_i  (rd),
    .write_i (wr),
    .adr_i   (adr),
    .dat_i   (dat_out),
    .extra_i (busy_extra),
    .busy_o  (busy),
    .dat_o   (dat_in)
  );

  always #50 clk = ~clk;

  // Key at column 2, row 1
  always @(negedge clk) begin
    rows <= (key_down && !cols[2]) ? 4'b1101 : 4'b1111;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [2:0] take_bits3();
    logic [2:0] v;
    v = '0;
    for (int i = 0; i < 3; i++) begin
      v    = {v[1:0], lfsr[31]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  always @(posedge clk) begin
    if (rand_busy) busy_extra <= take_bits3() % 6;
    else busy_extra <= 3'd0;
  end

  function automatic logic [31:0] encode_r(logic [4:0] rd_r, logic [2:0] f3, logic [4:0] rs1,
                                           logic [4:0] rs2, logic sub);
    return {1'b0, sub, 5'b0, rs2, rs1, f3, rd_r, OP_REG};
  endfunction

  function automatic logic [31:0] encode_i(opcode_e op, logic [4:0] rd_r, logic [2:0] f3,
                                           logic [4:0] rs1, logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd_r, op};
  endfunction

  function automatic logic [31:0] encode_s(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] encode_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] encode_u(opcode_e op, logic [4:0] rd_r, logic [31:0] imm20);
    return {imm20[19:0], rd_r, op};
  endfunction

  function automatic logic [31:0] encode_j(logic [4:0] rd_r, logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd_r, OP_JAL};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic clear_memory();
    prog_idx = 0;
    exp_cnt  = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model.mem[i] = 32'h5EED_0000 ^ (i << 7) ^ i;
    end
  endtask

  task automatic emit(input logic [31:0] w);
    mem_model.mem[(RESET_PC >> 2) + prog_idx] = w;
    prog_idx++;
  endtask

  task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
    exp_adr[exp_cnt] = a;
    exp_dat[exp_cnt] = d;
    exp_cnt++;
  endtask

  // Ends every program with the done store and a self loop
  task automatic emit_done();
    emit(encode_i(OP_IMM, 31, 3'b000, 0, 1));
    emit(encode_s(31, 0, DONE_ADR));
    emit(encode_j(0, 0));
    expect_store(DONE_ADR, 32'd1);
  endtask

  task automatic pulse_reset(input bit check_i);
    @(negedge clk);
    rst_n = 1'b0;
    repeat (8) begin
      @(negedge clk);
      if (check_i) begin
        check_value("read_o in reset", {31'b0, rd}, 32'd0);
        check_value("write_o in reset", {31'b0, wr}, 32'd0);
        check_value("cols_o in reset", {28'b0, cols}, 32'hE);
      end
    end
    rst_n = 1'b1;
  endtask

  task automatic wait_done();
    @(posedge clk);
    while (!(mem_model.log_cnt > 0 && mem_model.log_adr[mem_model.log_cnt-1] == DONE_ADR)) begin
      @(posedge clk);
    end
  endtask

  task automatic compare_stores(input string name);
    check_value({name, " store count"}, mem_model.log_cnt, exp_cnt);
    for (int i = 0; i < exp_cnt && i < mem_model.log_cnt; i++) begin
      check_value({name, " store address"}, mem_model.log_adr[i], exp_adr[i]);
      check_value({name, " store data"}, mem_model.log_dat[i], exp_dat[i]);
    end
  endtask

  task automatic build_arith();
    logic [31:0] e [13];
    clear_memory();
    emit(encode_u(OP_LUI, 1, 32'h12345));
    emit(encode_u(OP_AUIPC, 2, 32'h1));
    emit(encode_i(OP_IMM, 3, 3'b000, 1, -1));
    emit(encode_i(OP_IMM, 4, 3'b000, 0, 100));
    emit(encode_i(OP_IMM, 5, 3'b000, 0, -7));
    emit(encode_r(6, 3'b000, 4, 5, 1'b0));
    emit(encode_r(7, 3'b000, 4, 5, 1'b1));
    emit(encode_r(8, 3'b111, 3, 5, 1'b0));
    emit(encode_r(9, 3'b110, 4, 1, 1'b0));
    emit(encode_r(10, 3'b100, 1, 3, 1'b0));
    emit(encode_r(11, 3'b010, 5, 4, 1'b0));
    emit(encode_r(12, 3'b010, 4, 5, 1'b0));
    for (int k = 1; k <= 12; k++) begin
      emit(encode_s(k, 0, 32'h100 + 4 * (k - 1)));
    end
    // Expected register values from the instruction definitions
    e[1]  = 32'h12345 << 12;
    e[2]  = RESET_PC + 32'd4 + (32'h1 << 12);
    e[3]  = e[1] + 32'hFFFF_FFFF;
    e[4]  = 32'd100;
    e[5]  = 32'd0 - 32'd7;
    e[6]  = e[4] + e[5];
    e[7]  = e[4] - e[5];
    e[8]  = e[3] & e[5];
    e[9]  = e[4] | e[1];
    e[10] = e[1] ^ e[3];
    e[11] = ($signed(e[5]) < $signed(e[4])) ? 32'd1 : 32'd0;
    e[12] = ($signed(e[4]) < $signed(e[5])) ? 32'd1 : 32'd0;
    for (int k = 1; k <= 12; k++) begin
      expect_store(32'h100 + 4 * (k - 1), e[k]);
    end
    emit_done();
  endtask

  task automatic test_reset();
    bit seen;
    build_arith();
    pulse_reset(1'b1);
    seen = 1'b0;
    for (int i = 0; i < 2 && !seen; i++) begin
      @(negedge clk);
      if (rd) begin
        seen = 1'b1;
        check_value("first fetch address", adr, RESET_PC);
      end
    end
    if (!seen) begin
      errors++;
      $display("No fetch strobe appeared within 2 cycles after reset");
    end
  endtask

  task automatic test_arith(input string name);
    build_arith();
    pulse_reset(1'b0);
    wait_done();
    compare_stores(name);
  endtask

  task automatic test_load_store();
    logic [31:0] a, b;
    clear_memory();
    a = 32'hCAFE_0001;
    b = 32'h0000_00FF;
    mem_model.mem[32'h200 >> 2] = a;
    mem_model.mem[32'h204 >> 2] = b;
    emit(encode_i(OP_IMM, 1, 3'b000, 0, 32'h200));
    emit(encode_i(OP_LOAD, 2, 3'b010, 1, 0));
    emit(encode_i(OP_LOAD, 3, 3'b010, 1, 4));
    emit(encode_r(4, 3'b000, 2, 3, 1'b0));
    emit(encode_s(4, 1, 8));
    emit(encode_r(5, 3'b100, 2, 3, 1'b0));
    emit(encode_s(5, 1, 0));
    emit(encode_i(OP_LOAD, 6, 3'b010, 1, 0));
    emit(encode_i(OP_IMM, 6, 3'b000, 6, 16));
    emit(encode_s(6, 1, 12));
    expect_store(32'h208, a + b);
    expect_store(32'h200, a ^ b);
    expect_store(32'h20C, (a ^ b) + 32'd16);
    emit_done();
    pulse_reset(1'b0);
    wait_done();
    compare_stores("load/store");
  endtask

  task automatic test_branch();
    clear_memory();
    emit(encode_i(OP_IMM, 1, 3'b000, 0, 0));
    emit(encode_i(OP_IMM, 2, 3'b000, 0, 1));
    emit(encode_i(OP_IMM, 3, 3'b000, 0, 11));
    emit(encode_r(1, 3'b000, 1, 2, 1'b0));
    emit(encode_i(OP_IMM, 2, 3'b000, 2, 1));
    emit(encode_b(3'b100, 2, 3, -8));
    emit(encode_b(3'b001, 1, 0, 8));
    emit(encode_i(OP_IMM, 1, 3'b000, 0, 0));
    emit(encode_s(1, 0, 32'h300));
    // JAL at word 9 skips one instruction
    emit(encode_j(5, 8));
    emit(encode_i(OP_IMM, 5, 3'b000, 0, 0));
    emit(encode_s(5, 0, 32'h304));
    expect_store(32'h300, 32'd55);
    expect_store(32'h304, RESET_PC + 32'd9 * 4 + 32'd4);
    emit_done();
    pulse_reset(1'b0);
    wait_done();
    compare_stores("branch");
  endtask

  task automatic test_keypad();
    clear_memory();
    emit(encode_u(OP_LUI, 1, 32'h1));
    emit(encode_i(OP_IMM, 1, 3'b000, 1, KEYPAD_ADDR - 32'h1000));
    // Poll until bit 31 makes the word negative
    emit(encode_i(OP_LOAD, 2, 3'b010, 1, 0));
    emit(encode_b(3'b100, 2, 0, 8));
    emit(encode_j(0, -8));
    emit(encode_u(OP_LUI, 4, 32'h80000));
    emit(encode_r(3, 3'b000, 2, 4, 1'b1));
    emit(encode_s(3, 0, 32'h310));
    emit(encode_i(OP_LOAD, 5, 3'b010, 1, 0));
    emit(encode_s(5, 0, 32'h314));
    emit_done();
    key_down = 1'b0;
    pulse_reset(1'b0);
    repeat (40) @(negedge clk);
    key_down = 1'b1;
    wait_done();
    check_value("keypad store count", mem_model.log_cnt, 3);
    check_value("key code", mem_model.log_dat[0], 32'd9);
    check_value("second read bit 31", {31'b0, mem_model.log_dat[1][31]}, 32'd0);
    @(negedge clk);
    key_down = 1'b0;
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    rand_busy  = 1'b0;
    key_down   = 1'b0;
    rows       = 4'b1111;
    busy_extra = 3'd0;
    lfsr       = 32'h2c29_6732;
    errors     = 0;
    checks     = 0;
    cycles     = 0;
    test_reset();
    test_arith("arith");
    test_load_store();
    test_branch();
    rand_busy = 1'b1;
    test_arith("arith with busy");
    rand_busy = 1'b0;
    test_keypad();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
common/cpu_pkg.sv
core/control_unit.sv
core/alu.sv
core/register_file.sv
core/cpu_core.sv
rtl/request_unit.sv
rtl/keypad_scanner.sv
rtl/cpu_top.sv
sim/bus_mem_model.sv
sim/tb_cpu_top.sv

// File: Bender.yml
package:
  name: cpu_subsystem

sources:
  - common/cpu_pkg.sv
  - core/control_unit.sv
  - core/alu.sv
  - core/register_file.sv
  - core/cpu_core.sv
  - rtl/request_unit.sv
  - rtl/keypad_scanner.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - sim/bus_mem_model.sv
      - sim/tb_cpu_top.sv
